// ==== Bender.yml ====
package:
  name: cpu

sources:
  - cpuPkg.sv
  - alu.sv
  - regFile.sv
  - control.sv
  - cpu.sv
  - target: test
    files:
      - clockGen.sv
      - cpu_properties.sv
      - cpuTb.sv

// ==== alu.sv ====
`timescale 1ns/1ns

module alu (
    input  cpuPkg::dataT    dataA,
    input  cpuPkg::dataT    dataB,
    input  cpuPkg::aluModeT mode,
    input  logic            cin,
    output cpuPkg::dataT    result,
    output logic            cout,
    output logic            zout,
    output logic            nout
);
    import cpuPkg::*;

    // One extra bit on top catches carry or borrow
    logic [dataWidth:0] wide;
    logic [dataWidth:0] extA;
    logic [dataWidth:0] extB;
    logic [dataWidth:0] extCin;

    assign extA   = {1'b0, dataA};
    assign extB   = {1'b0, dataB};
    assign extCin = {{dataWidth{1'b0}}, cin};

    //**********************************************************
    // Operation select
    //**********************************************************
    always_comb begin
        case (mode)
            aluPassA: wide = extA;
            aluPassB: wide = extB;
            aluAdd:   wide = extA + extB;
            aluAdc:   wide = extA + extB + extCin;
            aluSub:   wide = extA - extB;          // Top bit set on borrow
            aluAnd:   wide = {1'b0, dataA & dataB};
            aluOr:    wide = {1'b0, dataA | dataB};
            aluXor:   wide = {1'b0, dataA ^ dataB};
            default:  wide = extA;
        endcase
    end

    //**********************************************************
    // Result and flags
    //**********************************************************
    assign result = wide[dataWidth-1:0];

    // Logic and pass modes never set the top bit, so carry reads 0 there
    assign cout = wide[dataWidth];
    assign zout = (result == '0);
    assign nout = result[dataWidth-1];     // Sign bit

endmodule

// ==== clockGen.sv ====
`timescale 1ns/1ns

module clockGen (
    output logic clk,
    output logic reset
);
    localparam int halfPeriod  = 2;    // 4 ns clock
    localparam int resetCycles = 4;

    initial begin
        clk = 1'b0;
        forever #halfPeriod clk = ~clk;
    end

    // Released just after an edge, like the other inputs
    initial begin
        reset = 1'b1;
        repeat (resetCycles) @(posedge clk);
        #1 reset = 1'b0;
    end

endmodule

// ==== control.sv ====
`timescale 1ns/1ns

module control (
    input  logic             clk,
    input  logic             reset,
    input  cpuPkg::instrT    instr,
    input  logic             carryFlag,
    input  logic             zeroFlag,
    output cpuPkg::regSrcT   regSrc,
    output logic             regWriteEn,
    output cpuPkg::aluBSrcT  aluBSrc,
    output cpuPkg::aluModeT  aluMode,
    output cpuPkg::dAddrSrcT dAddrSrc,
    output logic             flagEnable,
    output cpuPkg::iAddrSrcT iAddrSrc,
    output logic             pcWriteEn,
    output logic             iMemReadEnable,
    output logic             dMemIOReadEn,
    output logic             dMemIOWriteEn
);
    import cpuPkg::*;

    stateT  state;
    stateT  nextState;
    opcodeT opcode;
    logic   branchTaken;

    assign opcode = opcodeT'(instr[3:0]);

    //**********************************************************
    // State register
    //**********************************************************
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= stFetch;
        end else begin
            state <= nextState;
        end
    end

    // Jump condition from the stored flags
    always_comb begin
        case (opcode)
            opJmp:   branchTaken = 1'b1;
            opBrz:   branchTaken = zeroFlag;
            opBrc:   branchTaken = carryFlag;
            default: branchTaken = 1'b0;
        endcase
    end

    // ALU function per opcode, stores and IO writes pass Rd through
    always_comb begin
        case (opcode)
            opAdd:   aluMode = aluAdd;
            opAdc:   aluMode = aluAdc;
            opSub:   aluMode = aluSub;
            opAnd:   aluMode = aluAnd;
            opOr:    aluMode = aluOr;
            opXor:   aluMode = aluXor;
            opMov:   aluMode = aluPassB;
            default: aluMode = aluPassA;
        endcase
    end

    //**********************************************************
    // Selects and strobes
    //**********************************************************
    always_comb begin
        regSrc         = regSrcAlu;
        regWriteEn     = 1'b0;
        aluBSrc        = aluBReg;     // Immediate leg not used by this ISA
        dAddrSrc       = dAddrPair;
        flagEnable     = 1'b0;
        iAddrSrc       = iAddrPc;
        pcWriteEn      = 1'b0;
        iMemReadEnable = 1'b0;
        dMemIOReadEn   = 1'b0;
        dMemIOWriteEn  = 1'b0;
        nextState      = stFetch;

        case (state)
            stFetch: begin
                iMemReadEnable = 1'b1;
                nextState      = stExecute;
            end

            stExecute: begin
                pcWriteEn = 1'b1;                       // PC+1 or jump target
                if (branchTaken) begin
                    iAddrSrc = iAddrPair;
                end
                case (opcode)
                    opLdi: begin
                        regSrc     = regSrcImm;
                        regWriteEn = 1'b1;
                    end
                    opAdd, opAdc, opSub, opAnd, opOr, opXor: begin
                        regWriteEn = 1'b1;
                        flagEnable = 1'b1;
                    end
                    opMov: regWriteEn = 1'b1;           // Flags untouched
                    opLd: begin
                        dMemIOReadEn = 1'b1;
                        nextState    = stMemWait;
                    end
                    opIn: begin
                        dAddrSrc     = dAddrIo;
                        dMemIOReadEn = 1'b1;
                        nextState    = stMemWait;
                    end
                    opSt:  dMemIOWriteEn = 1'b1;
                    opOut: begin
                        dAddrSrc      = dAddrIo;
                        dMemIOWriteEn = 1'b1;
                    end
                    default: ;                          // Jumps and nop
                endcase
            end

            stMemWait: begin
                regSrc     = regSrcMem;                 // Read data arrives now
                regWriteEn = 1'b1;
            end

            default: nextState = stFetch;
        endcase
    end

endmodule

// ==== cpu.sv ====
`timescale 1ns/1ns

module cpu (
    input  logic          clk,
    input  logic          reset,
    output cpuPkg::addrT  iMemAddress,
    input  cpuPkg::instrT iMemOut,
    output logic          iMemReadEnable,
    output cpuPkg::addrT  dMemIOAddress,
    output cpuPkg::dataT  dMemIOIn,
    input  cpuPkg::dataT  dMemIOOut,
    output logic          dMemIOWriteEn,
    output logic          dMemIOReadEn
);
    import cpuPkg::*;

    regSrcT   regSrc;
    aluBSrcT  aluBSrc;
    aluModeT  aluMode;
    dAddrSrcT dAddrSrc;
    iAddrSrcT iAddrSrc;
    logic     regWriteEn;
    logic     flagEnable;
    logic     pcWriteEn;
    logic     carryFlag;
    logic     zeroFlag;

    regIdxT   destSel;
    regIdxT   srcSel;
    dataT     imm8;
    dataT     regIn;
    dataT     regA;
    dataT     regB;
    dataT     regC;
    dataT     aluB;
    dataT     aluOut;
    logic     aluCarry;
    logic     aluZero;
    logic     aluNeg;
    logic [2:0] status;         // {negative, zero, carry}
    addrT     pairAddr;
    addrT     currentAddress;
    addrT     pc;
    addrT     pcNext;

    // Instruction fields
    assign destSel = iMemOut[15:12];
    assign imm8    = iMemOut[11:4];
    assign srcSel  = iMemOut[11:8];   // Upper immediate nibble

    //**********************************************************
    // Control and datapath blocks
    //**********************************************************
    control i_control (
        .clk(clk), .reset(reset), .instr(iMemOut),
        .carryFlag(carryFlag), .zeroFlag(zeroFlag),
        .regSrc(regSrc), .regWriteEn(regWriteEn),
        .aluBSrc(aluBSrc), .aluMode(aluMode),
        .dAddrSrc(dAddrSrc), .flagEnable(flagEnable),
        .iAddrSrc(iAddrSrc), .pcWriteEn(pcWriteEn),
        .iMemReadEnable(iMemReadEnable), .dMemIOReadEn(dMemIOReadEn),
        .dMemIOWriteEn(dMemIOWriteEn)
    );

    regFile i_regFile (
        .clk(clk), .writeSel(destSel), .readSel(srcSel),
        .writeData(regIn), .writeEn(regWriteEn),
        .outA(regA), .outB(regB), .outC(regC)
    );

    alu i_alu (
        .dataA(regA), .dataB(aluB), .mode(aluMode), .cin(carryFlag),
        .result(aluOut), .cout(aluCarry), .zout(aluZero), .nout(aluNeg)
    );

    //**********************************************************
    // Muxes
    //**********************************************************
    always_comb begin
        case (regSrc)
            regSrcImm: regIn = imm8;
            regSrcMem: regIn = dMemIOOut;
            default:   regIn = aluOut;
        endcase
    end

    assign aluB     = (aluBSrc == aluBImm) ? imm8 : regB;
    assign pairAddr = {regC, regB};                     // High byte first
    assign dMemIOAddress = (dAddrSrc == dAddrIo) ? {ioPage, imm8} : pairAddr;
    assign dMemIOIn = aluOut;                           // Pass-A of Rd on writes

    //**********************************************************
    // Status, current address and PC
    //**********************************************************
    always_ff @(posedge clk) begin
        if (reset) begin
            status <= '0;
        end else if (flagEnable) begin
            status <= {aluNeg, aluZero, aluCarry};
        end
    end

    assign carryFlag = status[0];
    assign zeroFlag  = status[1];

    // Address of the instruction being executed
    always_ff @(posedge clk) begin
        if (iMemReadEnable) begin
            currentAddress <= iMemAddress;
        end
    end

    assign pcNext = (iAddrSrc == iAddrPair) ? pairAddr : currentAddress + addrT'(1);

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= resetPc;
        end else if (pcWriteEn) begin
            pc <= pcNext;
        end
    end

    assign iMemAddress = pc;

endmodule

// ==== cpuPkg.sv ====
package cpuPkg;

    //**********************************************************
    // Widths and fixed values
    //**********************************************************
    localparam int dataWidth  = 8;
    localparam int addrWidth  = 16;
    localparam int instrWidth = 16;
    localparam int regCount   = 16;

    typedef logic [dataWidth-1:0]         dataT;
    typedef logic [addrWidth-1:0]         addrT;
    typedef logic [instrWidth-1:0]        instrT;
    typedef logic [$clog2(regCount)-1:0]  regIdxT;

    localparam dataT ioPage  = 8'h10;   // Upper byte of every IO address
    localparam addrT resetPc = '0;

    //**********************************************************
    // Instruction set, opcode lives in bits 3..0
    //**********************************************************
    typedef enum logic [3:0] {
        opLdi = 4'h0,
        opAdd = 4'h1,
        opAdc = 4'h2,
        opSub = 4'h3,
        opAnd = 4'h4,
        opOr  = 4'h5,
        opXor = 4'h6,
        opMov = 4'h7,
        opLd  = 4'h8,   // Rd <= mem[pair]
        opSt  = 4'h9,   // mem[pair] <= Rd
        opIn  = 4'hA,
        opOut = 4'hB,
        opJmp = 4'hC,
        opBrz = 4'hD,
        opBrc = 4'hE,
        opNop = 4'hF
    } opcodeT;

    typedef enum logic [2:0] {
        aluPassA,
        aluPassB,
        aluAdd,
        aluAdc,
        aluSub,     // Carry out means borrow
        aluAnd,
        aluOr,
        aluXor
    } aluModeT;

    typedef enum logic [1:0] {
        stFetch,
        stExecute,
        stMemWait
    } stateT;

    // Datapath mux selects
    typedef enum logic [1:0] {regSrcAlu, regSrcImm, regSrcMem} regSrcT;
    typedef enum logic {aluBReg, aluBImm} aluBSrcT;
    typedef enum logic {dAddrPair, dAddrIo} dAddrSrcT;
    typedef enum logic {iAddrPc, iAddrPair} iAddrSrcT;

endpackage

// ==== cpuTb.sv ====
`timescale 1ns/1ns

module cpuTb;
    import cpuPkg::*;

    localparam int driveDelay = 1;
    // About 100 instructions at up to 3 cycles each, plus halt loops and margin
    localparam int maxCycles  = 2000;

    logic  clk;
    logic  reset;
    addrT  iMemAddress;
    instrT iMemOut = '0;
    logic  iMemReadEnable;
    addrT  dMemIOAddress;
    dataT  dMemIOIn;
    dataT  dMemIOOut = '0;
    logic  dMemIOWriteEn;
    logic  dMemIOReadEn;

    instrT imem [256];
    dataT  dmem [65536];
    addrT  fetchLog [$];
    addrT  expAddrQ [$];
    dataT  expDataQ [$];
    addrT  pcTop;              // Next free instruction slot
    addrT  haltAddr;           // Jump-to-self that parks the CPU
    logic  modelCarry = 1'b0;
    int    errorCount = 0;
    int    cycleCount = 0;

    clockGen i_clockGen (.clk(clk), .reset(reset));

    cpu i_cpu (
        .clk(clk), .reset(reset),
        .iMemAddress(iMemAddress), .iMemOut(iMemOut), .iMemReadEnable(iMemReadEnable),
        .dMemIOAddress(dMemIOAddress), .dMemIOIn(dMemIOIn), .dMemIOOut(dMemIOOut),
        .dMemIOWriteEn(dMemIOWriteEn), .dMemIOReadEn(dMemIOReadEn)
    );

    bind cpu cpu_properties i_cpuProperties (
        .clk(clk), .reset(reset), .iMemReadEnable(iMemReadEnable),
        .dMemIOReadEn(dMemIOReadEn), .dMemIOWriteEn(dMemIOWriteEn)
    );

    //**********************************************************
    // Compare tasks
    //**********************************************************
    task automatic checkData(string name, dataT actual, dataT expected);
        if (actual !== expected) begin
            errorCount++;
            $display("ERROR %0t %s: got %h expected %h", $time, name, actual, expected);
        end
    endtask

    task automatic checkAddr(string name, addrT actual, addrT expected);
        if (actual !== expected) begin
            errorCount++;
            $display("ERROR %0t %s: got %h expected %h", $time, name, actual, expected);
        end
    endtask

    task automatic checkWrite(addrT addr, dataT value);
        if (expAddrQ.size() == 0) begin
            errorCount++;
            $display("Unexpected data write of %h to %h at %0t", value, addr, $time);
        end else begin
            checkAddr("dMemIOAddress", addr, expAddrQ.pop_front());
            checkData("dMemIOIn", value, expDataQ.pop_front());
        end
    endtask

    //**********************************************************
    // Memory models and bus monitor
    //**********************************************************
    // Sample mid-cycle, update on the edge, drive 1 ns later
    always begin : memoryModel
        logic fetchReq;
        logic readReq;
        logic writeReq;
        addrT fetchAddr;
        addrT dataAddr;
        dataT writeVal;
        @(negedge clk);
        fetchReq  = iMemReadEnable;
        readReq   = dMemIOReadEn;
        writeReq  = dMemIOWriteEn;
        fetchAddr = iMemAddress;
        dataAddr  = dMemIOAddress;
        writeVal  = dMemIOIn;
        if (fetchReq && !reset) begin
            fetchLog.push_back(fetchAddr);
        end
        if (writeReq) begin
            checkWrite(dataAddr, writeVal);
        end
        @(posedge clk);
        if (writeReq) begin
            dmem[dataAddr] = writeVal;
        end
        #driveDelay;
        if (fetchReq) begin
            iMemOut = imem[fetchAddr[7:0]];
        end
        if (readReq) begin
            dMemIOOut = dmem[dataAddr];
        end
    end

    //**********************************************************
    // Program building
    //**********************************************************
    function automatic instrT encode(regIdxT rd, dataT imm, opcodeT op);
        return {rd, imm, op};
    endfunction

    function automatic dataT srcImm(regIdxT src);
        return {src, 4'h0};    // Source register sits in the upper nibble
    endfunction

    task automatic emit(instrT word);
        imem[pcTop[7:0]] = word;
        pcTop++;
    endtask

    task automatic loadPair(regIdxT low, addrT value);
        emit(encode(low, value[7:0], opLdi));
        emit(encode(low + regIdxT'(1), value[15:8], opLdi));
    endtask

    task automatic expectWrite(addrT addr, dataT value);
        expAddrQ.push_back(addr);
        expDataQ.push_back(value);
    endtask

    // Parks the CPU on a jump to itself through r14/r15
    task automatic appendHalt();
        haltAddr = pcTop + addrT'(2);
        loadPair(4'd14, haltAddr);
        emit(encode(4'd0, srcImm(4'd14), opJmp));
    endtask

    task automatic waitFetch(addrT target);
        @(negedge clk);
        while (reset || !iMemReadEnable || iMemAddress != target) begin
            @(negedge clk);
        end
    endtask

    // Turn the old halt into a nop so the CPU runs into the new code
    task automatic runProgram();
        addrT oldHalt;
        oldHalt = haltAddr;
        appendHalt();
        @(negedge clk);
        imem[oldHalt[7:0]] = encode(4'd0, 8'h00, opNop);
        waitFetch(haltAddr);
        @(posedge clk);
        if (expAddrQ.size() != 0) begin
            errorCount++;
            $display("%0d expected data writes never happened", expAddrQ.size());
            expAddrQ.delete();
            expDataQ.delete();
        end
    endtask

    function automatic addrT fetchAfter(addrT from);
        for (int i = 0; i + 1 < fetchLog.size(); i++) begin
            if (fetchLog[i] == from) begin
                return fetchLog[i + 1];
            end
        end
        return '1;
    endfunction

    // Expected ALU results from the carry and borrow rules
    function automatic dataT aluModel(opcodeT op, dataT a, dataT b);
        int   sum;
        dataT res;
        case (op)
            opAdd, opAdc: begin
                sum = int'(a) + int'(b) + ((op == opAdc && modelCarry) ? 1 : 0);
                res = dataT'(sum);
                modelCarry = (sum > 255);
            end
            opSub: begin
                res = a - b;
                modelCarry = (b > a);   // Borrow
            end
            opAnd: begin
                res = a & b;
                modelCarry = 1'b0;
            end
            opOr: begin
                res = a | b;
                modelCarry = 1'b0;
            end
            opXor: begin
                res = a ^ b;
                modelCarry = 1'b0;
            end
            opMov:   res = b;
            default: res = a;
        endcase
        return res;
    endfunction

    //**********************************************************
    // Directed tests
    //**********************************************************
    task automatic testReset();
        @(negedge clk);
        while (reset) begin
            if (dMemIOReadEn || dMemIOWriteEn) begin
                errorCount++;
                $display("Data strobe high during reset at %0t", $time);
            end
            @(negedge clk);
        end
        if (!iMemReadEnable) begin
            errorCount++;
            $display("No fetch in the first cycle after reset at %0t", $time);
        end
        if (dMemIOReadEn || dMemIOWriteEn) begin
            errorCount++;
            $display("Data strobe high in the first fetch cycle at %0t", $time);
        end
        checkAddr("iMemAddress", iMemAddress, resetPc);
        waitFetch(haltAddr);
    endtask

    task automatic testIoWrite();
        dataT value;
        dataT offset;
        value  = $urandom;
        offset = $urandom;
        emit(encode(4'd3, value, opLdi));
        emit(encode(4'd3, offset, opOut));
        expectWrite({ioPage, offset}, value);
        runProgram();
    endtask

    task automatic testAluOps();
        opcodeT ops [7];
        dataT   a;
        dataT   b;
        dataT   offset;
        ops = '{opAdd, opAdc, opSub, opAnd, opOr, opXor, opMov};
        for (int i = 0; i < 7; i++) begin
            a = $urandom;
            b = $urandom;
            if (ops[i] == opAdd) begin
                a[7] = 1'b1;    // Force a carry into the adc that follows
                b[7] = 1'b1;
            end
            offset = 8'h20 + dataT'(i);
            emit(encode(4'd1, a, opLdi));
            emit(encode(4'd2, b, opLdi));
            emit(encode(4'd1, srcImm(4'd2), ops[i]));
            emit(encode(4'd1, offset, opOut));
            expectWrite({ioPage, offset}, aluModel(ops[i], a, b));
        end
        runProgram();
    endtask

    task automatic testPairMemory();
        addrT pairAddr;
        dataT value;
        dataT offset;
        pairAddr = $urandom;
        value    = $urandom;
        offset   = $urandom;
        loadPair(4'd4, pairAddr);
        emit(encode(4'd6, value, opLdi));
        emit(encode(4'd6, srcImm(4'd4), opSt));
        emit(encode(4'd7, srcImm(4'd4), opLd));     // Read back into another register
        emit(encode(4'd7, offset, opOut));
        expectWrite(pairAddr, value);
        expectWrite({ioPage, offset}, value);
        runProgram();
    endtask

    task automatic testBranches();
        addrT brzAt;
        addrT brzFallAt;
        addrT brcAt;
        dataT x;
        x = $urandom;
        // Equal operands, sub leaves zero set
        emit(encode(4'd1, x, opLdi));
        emit(encode(4'd2, x, opLdi));
        emit(encode(4'd1, srcImm(4'd2), opSub));
        brzAt = pcTop + addrT'(2);
        loadPair(4'd8, brzAt + addrT'(2));
        emit(encode(4'd0, srcImm(4'd8), opBrz));
        emit(encode(4'd1, 8'hEE, opOut));           // Skipped when taken
        // Nonzero or result, brz must fall through
        emit(encode(4'd1, 8'h0F, opLdi));
        emit(encode(4'd2, 8'hF0, opLdi));
        emit(encode(4'd1, srcImm(4'd2), opOr));
        brzFallAt = pcTop + addrT'(2);
        loadPair(4'd8, brzFallAt + addrT'(3));
        emit(encode(4'd0, srcImm(4'd8), opBrz));
        emit(encode(4'd0, 8'h00, opNop));
        emit(encode(4'd0, 8'h00, opNop));
        // Overflowing add sets carry
        emit(encode(4'd1, x | 8'h80, opLdi));
        emit(encode(4'd2, 8'h80, opLdi));
        emit(encode(4'd1, srcImm(4'd2), opAdd));
        brcAt = pcTop + addrT'(2);
        loadPair(4'd8, brcAt + addrT'(2));
        emit(encode(4'd0, srcImm(4'd8), opBrc));
        emit(encode(4'd1, 8'hEF, opOut));
        runProgram();
        checkAddr("iMemAddress", fetchAfter(brzAt), brzAt + addrT'(2));
        checkAddr("iMemAddress", fetchAfter(brzFallAt), brzFallAt + addrT'(1));
        checkAddr("iMemAddress", fetchAfter(brcAt), brcAt + addrT'(2));
    endtask

    //**********************************************************
    // Run control
    //**********************************************************
    task automatic reportAndFinish();
        int assertCount;
        assertCount = i_cpu.i_cpuProperties.assertFails;
        $display("Errors: %0d check failures, %0d assertion failures",
                 errorCount, assertCount);
        if (errorCount == 0 && assertCount == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    endtask

    initial begin
        while (cycleCount < maxCycles) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("Timeout after %0d cycles, the CPU never reached its halt", maxCycles);
        errorCount++;
        reportAndFinish();
    end

    initial begin
        void'($urandom(32'h5ab3_a09c));
        for (int a = 0; a < 256; a++) begin
            imem[a] = {8'(a), 4'h0, opNop};
        end
        for (int a = 0; a < 65536; a++) begin
            dmem[a] = dataT'(a[15:8] ^ a[7:0]);
        end
        pcTop = resetPc;
        appendHalt();               // First program is just the halt
        testReset();
        testIoWrite();
        testAluOps();
        testPairMemory();
        testBranches();
        reportAndFinish();
    end

endmodule

// ==== cpu_properties.sv ====
`timescale 1ns/1ns

module cpu_properties (
    input logic clk,
    input logic reset,
    input logic iMemReadEnable,
    input logic dMemIOReadEn,
    input logic dMemIOWriteEn
);
    int assertFails = 0;    // Read by the testbench at the end of the run

    // Read and write never share a cycle
    assert property (@(posedge clk) disable iff (reset)
        !(dMemIOReadEn && dMemIOWriteEn))
        else begin
            assertFails++;
            $error("Data read and write strobes high in the same cycle");
        end

    // Fetch cycles leave the data bus alone
    assert property (@(posedge clk) disable iff (reset)
        iMemReadEnable |-> !(dMemIOReadEn || dMemIOWriteEn))
        else begin
            assertFails++;
            $error("Data strobe high during a fetch cycle");
        end

    assert property (@(posedge clk) disable iff (reset)
        dMemIOReadEn |-> ##[1:2] iMemReadEnable)
        else begin
            assertFails++;
            $error("No fetch within 2 cycles of a data read");
        end

endmodule

// ==== regFile.sv ====
`timescale 1ns/1ns

module regFile (
    input  logic           clk,
    input  cpuPkg::regIdxT writeSel,
    input  cpuPkg::regIdxT readSel,
    input  cpuPkg::dataT   writeData,
    input  logic           writeEn,
    output cpuPkg::dataT   outA,
    output cpuPkg::dataT   outB,
    output cpuPkg::dataT   outC
);
    import cpuPkg::*;

    //**********************************************************
    // Storage
    //**********************************************************
    dataT   regs [regCount];
    regIdxT pairSel;

    always_ff @(posedge clk) begin
        if (writeEn) begin
            regs[writeSel] <= writeData;
        end
    end

    //**********************************************************
    // Read ports
    //**********************************************************
    // High byte of the pair, index wraps from 15 back to 0
    assign pairSel = readSel + regIdxT'(1);

    // Destination register, also ALU operand A
    assign outA = regs[writeSel];

    assign outB = regs[readSel];    // Source register, pair low byte
    assign outC = regs[pairSel];    // Pair high byte

endmodule

// ==== tb.f ====
cpuPkg.sv
alu.sv
regFile.sv
control.sv
cpu.sv
clockGen.sv
cpu_properties.sv
cpuTb.sv
